//--- Makefile
# Verilator flow for the lens delta generator

LOG := sim.log

.PHONY: all lint sim clean

all: sim

# Lint the RTL top level
lint:
	verilator --lint-only --timing --top-module delta_generator -f vlog.f

# Build and run the testbench, then search the log for the pass line
sim:
	verilator --binary --timing --assert -j 0 --top-module tb_delta_generator -f vlog.f
	./obj_dir/Vtb_delta_generator | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- rtl/axis_offset_squarer.sv
module axis_offset_squarer
    import lens_pkg::*;
#(
    parameter int COORD_W = COL_W
) (
    input  logic                      i_clk,
    input  logic                      rst_n,
    input  logic                      pix_valid,
    input  logic signed [COORD_W-1:0] coord,
    axis_sq_if.src                    out
);

    // Wrapped tap coordinate per offset
    tap_coord_t                tap  [N_AXIS_TAPS];
    // Full signed product before narrowing
    logic signed [2*TAP_W-1:0] prod [N_AXIS_TAPS];
    // Square ready for the register
    sq_t                       sq_d [N_AXIS_TAPS];

    always_comb begin
        for (int i = 0; i < N_AXIS_TAPS; i++) begin
            // Offset add, then keep the low 9 bits as a signed value
            tap[i]  = tap_coord_t'(coord + TAP_OFFSET[i]);
            // Both operands signed, so the product is non-negative
            prod[i] = (2*TAP_W)'(tap[i]) * (2*TAP_W)'(tap[i]);
            // Largest square is 65536, fits in 17 bits
            sq_d[i] = sq_t'(prod[i]);
        end
    end

    // Square registers, loaded only for strobed pixels
    always_ff @(posedge i_clk) begin
        if (pix_valid) begin
            for (int i = 0; i < N_AXIS_TAPS; i++) begin
                out.sq[i] <= sq_d[i];
            end
        end
    end

    // Valid follows the strobe one cycle later
    always_ff @(posedge i_clk or negedge rst_n) begin
        if (!rst_n) begin
            out.sq_valid <= 1'b0;
        end else begin
            out.sq_valid <= pix_valid;
        end
    end

endmodule

//--- rtl/axis_sq_if.sv
interface axis_sq_if
    import lens_pkg::*;
();

    // Squared tap coordinates of one axis, in TAP_OFFSET order
    sq_t  sq [N_AXIS_TAPS];

    // High for one cycle per accepted pixel, no handshake
    logic sq_valid;

    // Squarer side
    modport src (
        output sq,
        output sq_valid
    );

    // Mapper side
    modport dst (
        input sq,
        input sq_valid
    );

endinterface

//--- rtl/delta_generator.sv
module delta_generator
    import lens_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    rst_n,
    input  logic                    pix_valid,
    input  logic signed [COL_W-1:0] p_x,
    input  logic signed [ROW_W-1:0] p_y,
    output logic                    delta_valid,
    output delta_t                  delta [N_TAPS]
);

    // Column squares, taps n mod 4
    axis_sq_if sq_x ();
    // Row squares, taps n div 4
    axis_sq_if sq_y ();

    // Stage 1 for the x axis
    axis_offset_squarer #(
        .COORD_W (COL_W)
    ) u_sq_x (
        .i_clk     (i_clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .coord     (p_x),
        .out       (sq_x.src)
    );

    // Stage 1 for the y axis, same strobe as x
    axis_offset_squarer #(
        .COORD_W (ROW_W)
    ) u_sq_y (
        .i_clk     (i_clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .coord     (p_y),
        .out       (sq_y.src)
    );

    // Stage 2, r2 per tap and threshold lookup
    radius_delta_mapper u_map (
        .i_clk       (i_clk),
        .rst_n       (rst_n),
        .sq_x        (sq_x.dst),
        .sq_y        (sq_y.dst),
        .delta_valid (delta_valid),
        .delta       (delta)
    );

endmodule

//--- rtl/lens_pkg.sv
package lens_pkg;

    // Image size in pixels
    localparam int PIXEL_COLUMN = 640;
    localparam int PIXEL_ROW    = 480;

    // Signed pixel offsets from the image centre
    localparam int COL_W = $clog2(PIXEL_COLUMN);
    localparam int ROW_W = $clog2(PIXEL_ROW);

    // Tap coordinate wraps to 9 bits signed
    localparam int TAP_W = 9;

    // Square of a 9-bit signed value peaks at 256*256, so 17 bits
    localparam int SQ_W = 17;

    // Radius squared, sized to hold every threshold entry
    localparam int R2_W = 19;

    // Output step width
    localparam int DELTA_W = 8;

    // 4x4 tap grid around the pixel
    localparam int N_TAPS      = 16;
    localparam int N_AXIS_TAPS = 4;

    // Threshold table depth and the width of a count over it (0..32)
    localparam int N_THRESH = 32;
    localparam int CNT_W    = $clog2(N_THRESH + 1);

    typedef logic signed [TAP_W-1:0] tap_coord_t;
    typedef logic [SQ_W-1:0]         sq_t;
    typedef logic [R2_W-1:0]         r2_t;
    typedef logic [DELTA_W-1:0]      delta_t;

    // Axis offsets in tap order
    // x takes index n mod 4, y takes index n div 4
    localparam int TAP_OFFSET [N_AXIS_TAPS] = '{120, 40, -40, -120};

    // Step when r2 is at or below the first threshold
    localparam delta_t DELTA_BASE = 8'd147;

    // Ascending r2 limits, squares of radii 62 .. 550
    // Each entry strictly below r2 adds one to the step
    localparam r2_t R2_THRESHOLD [N_THRESH] = '{
        // r = 62, 112, 146, 173
        19'd3844,   19'd12544,  19'd21316,  19'd29929,
        // r = 197, 219, 239, 257
        19'd38809,  19'd47961,  19'd57121,  19'd66049,
        // r = 274, 290, 306, 321
        19'd75076,  19'd84100,  19'd93636,  19'd103041,
        // r = 335, 349, 362, 375
        19'd112225, 19'd121801, 19'd131044, 19'd140625,
        // r = 388, 400, 412, 424
        19'd150544, 19'd160000, 19'd169744, 19'd179776,
        // r = 436, 447, 458, 469
        19'd190096, 19'd199809, 19'd209764, 19'd219961,
        // r = 479, 490, 500, 510
        19'd229441, 19'd240100, 19'd250000, 19'd260100,
        // r = 520, 530, 540, 550
        19'd270400, 19'd280900, 19'd291600, 19'd302500
    };

endpackage

//--- rtl/radius_delta_mapper.sv
module radius_delta_mapper
    import lens_pkg::*;
(
    input  logic    i_clk,
    input  logic    rst_n,
    axis_sq_if.dst  sq_x,
    axis_sq_if.dst  sq_y,
    output logic    delta_valid,
    output delta_t  delta [N_TAPS]
);

    // Radius squared per tap
    r2_t                 r2      [N_TAPS];
    // Bit j set when threshold j lies strictly below r2
    logic [N_THRESH-1:0] above   [N_TAPS];
    // Number of thresholds passed
    logic [CNT_W-1:0]    n_above [N_TAPS];
    // Step before the output register
    delta_t              delta_d [N_TAPS];

    // Counts set bits of the compare vector
    // The table is ascending, so this is also the thermometer level
    function automatic logic [CNT_W-1:0] count_ones(
        input logic [N_THRESH-1:0] therm
    );
        logic [CNT_W-1:0] cnt;
        cnt = '0;
        for (int j = 0; j < N_THRESH; j++) begin
            cnt = cnt + CNT_W'(therm[j]);
        end
        return cnt;
    endfunction

    genvar n;
    generate
        for (n = 0; n < N_TAPS; n++) begin : g_tap
            // x from the column index, y from the row index
            localparam int XI = n % N_AXIS_TAPS;
            localparam int YI = n / N_AXIS_TAPS;

            always_comb begin
                // Squares are unsigned, widen before the add
                r2[n] = r2_t'(sq_x.sq[XI]) + r2_t'(sq_y.sq[YI]);

                // Strict compare, r2 equal to a limit stays in the lower step
                for (int j = 0; j < N_THRESH; j++) begin
                    above[n][j] = (r2[n] > R2_THRESHOLD[j]);
                end

                n_above[n] = count_ones(above[n]);

                // Range 147 .. 179
                delta_d[n] = DELTA_BASE + delta_t'(n_above[n]);
            end
        end
    endgenerate

    // Step registers, updated only with valid squares
    // Both axes are strobed together, x valid stands for the pair
    always_ff @(posedge i_clk) begin
        if (sq_x.sq_valid) begin
            for (int t = 0; t < N_TAPS; t++) begin
                delta[t] <= delta_d[t];
            end
        end
    end

    // Second pipeline stage of the valid flag
    always_ff @(posedge i_clk or negedge rst_n) begin
        if (!rst_n) begin
            delta_valid <= 1'b0;
        end else begin
            delta_valid <= sq_x.sq_valid;
        end
    end

endmodule

//--- tb/delta_generator_assertions.sv
module delta_generator_assertions
    import lens_pkg::*;
(
    input logic   i_clk,
    input logic   rst_n,
    input logic   pix_valid,
    input logic   delta_valid,
    input delta_t delta [N_TAPS]
);
    timeunit 1ns;
    timeprecision 1ps;

    // Top of the step range, one step per threshold
    localparam delta_t DELTA_MAX = DELTA_BASE + delta_t'(N_THRESH);

    // Fixed two cycle latency from strobe to valid
    assert property (@(posedge i_clk) disable iff (!rst_n)
        delta_valid == $past(pix_valid, 2))
        else $error("delta_valid does not follow pix_valid by two cycles");

    // Held reset keeps the output idle
    assert property (@(posedge i_clk) !rst_n |=> !delta_valid)
        else $error("delta_valid high during reset");

    genvar g;
    generate
        for (g = 0; g < N_TAPS; g++) begin : g_range
            assert property (@(posedge i_clk) disable iff (!rst_n)
                delta_valid |-> (delta[g] >= DELTA_BASE && delta[g] <= DELTA_MAX))
                else $error("delta of tap %0d outside 147..179", g);
        end
    endgenerate

endmodule

bind delta_generator delta_generator_assertions u_assert (
    .i_clk       (i_clk),
    .rst_n       (rst_n),
    .pix_valid   (pix_valid),
    .delta_valid (delta_valid),
    .delta       (delta)
);

//--- tb/tb_delta_generator.sv
module tb_delta_generator
    import lens_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    // Clock half period for a 40 ns cycle
    localparam int HALF_PERIOD   = 20;
    // Input drive skew after the rising edge
    localparam int DRIVE_SKEW    = 2;
    localparam int RESET_CYCLES  = 16;
    // Longest wait for the pipeline to empty
    localparam int DRAIN_TIMEOUT = 50;
    // Delta when r2 passes no threshold
    localparam int REF_BASE      = 147;

    // One expected pixel result and the cycle it is due
    typedef struct packed {
        int                                 due;
        logic [N_TAPS-1:0][DELTA_W-1:0]     d;
    } exp_t;

    logic                    i_clk = 1'b0;
    logic                    rst_n;
    logic                    pix_valid;
    logic signed [COL_W-1:0] p_x;
    logic signed [ROW_W-1:0] p_y;
    logic                    delta_valid;
    delta_t                  delta [N_TAPS];

    int   seed      = 50;
    int   cycle     = 0;
    exp_t exp_q [$];

    delta_generator uut (
        .i_clk       (i_clk),
        .rst_n       (rst_n),
        .pix_valid   (pix_valid),
        .p_x         (p_x),
        .p_y         (p_y),
        .delta_valid (delta_valid),
        .delta       (delta)
    );

    initial begin
        forever #HALF_PERIOD i_clk = ~i_clk;
    end

    // Rising edge count, used to tag expected results
    always @(posedge i_clk) begin
        cycle <= cycle + 1;
    end

    // Two's complement wrap into -256 .. 255
    function automatic int wrap_to_nine_bits(input int v);
        int w;
        w = v % 512;
        if (w < 0) begin
            w = w + 512;
        end
        if (w >= 256) begin
            w = w - 512;
        end
        return w;
    endfunction

    // Expected delta of tap n for pixel (x, y)
    function automatic delta_t expected_delta(input int x, input int y, input int n);
        int tx;
        int ty;
        int r2;
        int cnt;
        tx  = wrap_to_nine_bits(x + TAP_OFFSET[n % N_AXIS_TAPS]);
        ty  = wrap_to_nine_bits(y + TAP_OFFSET[n / N_AXIS_TAPS]);
        r2  = tx * tx + ty * ty;
        cnt = 0;
        // Strictly below only, a limit equal to r2 does not count
        for (int j = 0; j < N_THRESH; j++) begin
            if (int'(R2_THRESHOLD[j]) < r2) begin
                cnt = cnt + 1;
            end
        end
        return delta_t'(REF_BASE + cnt);
    endfunction

    task automatic check_delta(input int tap, input delta_t exp_d, input delta_t act_d);
        if (act_d !== exp_d) begin
            $display("MISMATCH time=%0t signal=delta[%0d] expected=%0d actual=%0d",
                     $time, tap, exp_d, act_d);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_valid(input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH time=%0t signal=delta_valid expected=%b actual=%b",
                     $time, exp_v, act_v);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Strobe one pixel for one cycle and queue its expected taps
    task automatic send_pixel(input int x, input int y);
        exp_t e;
        pix_valid = 1'b1;
        p_x       = COL_W'(x);
        p_y       = ROW_W'(y);
        // Sampled at the next edge, valid two edges later
        e.due = cycle + 2;
        for (int t = 0; t < N_TAPS; t++) begin
            e.d[t] = expected_delta(x, y, t);
        end
        exp_q.push_back(e);
        @(posedge i_clk);
        #DRIVE_SKEW;
    endtask

    // Strobe low for n cycles
    task automatic idle(input int n);
        pix_valid = 1'b0;
        repeat (n) begin
            @(posedge i_clk);
            #DRIVE_SKEW;
        end
    endtask

    // Wait until every queued pixel has come out
    task automatic wait_drain();
        int guard;
        guard     = 0;
        pix_valid = 1'b0;
        while (exp_q.size() != 0 && guard < DRAIN_TIMEOUT) begin
            @(posedge i_clk);
            guard = guard + 1;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d pixel results never appeared on delta_valid",
                     exp_q.size());
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
        #DRIVE_SKEW;
    endtask

    // Mid-cycle sampling, outputs settle after the rising edge
    always @(negedge i_clk) begin : compare
        exp_t e;
        logic exp_v;
        exp_v = (exp_q.size() > 0) && (exp_q[0].due == cycle);
        check_valid(exp_v, delta_valid);
        if (delta_valid) begin
            e = exp_q.pop_front();
            for (int t = 0; t < N_TAPS; t++) begin
                check_delta(t, e.d[t], delta[t]);
            end
        end
    end

    initial begin : stimulus
        int rnd;
        int gap;
        rst_n     = 1'b0;
        pix_valid = 1'b0;
        p_x       = '0;
        p_y       = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #DRIVE_SKEW;
        rst_n = 1'b1;

        // Quiet pipeline, valid must stay low
        idle(20);

        // Centre pixel, r2 of 28800, 16000 or 3200
        send_pixel(0, 0);
        wait_drain();

        // Tap 0 on and just past the first two limits
        send_pixel(-58, -120);
        send_pixel(-57, -120);
        send_pixel(-8, -120);
        send_pixel(-7, -120);
        wait_drain();

        // Input extremes wrap the tap coordinate
        send_pixel(500, 0);
        send_pixel(511, 255);
        send_pixel(-512, -256);
        send_pixel(-500, 200);
        wait_drain();

        // Back to back strobes, two pixels in flight
        for (int i = 0; i < 200; i++) begin
            rnd = $random(seed);
            send_pixel(rnd >>> 22, rnd <<< 10 >>> 23);
        end
        wait_drain();

        // Random gaps between strobes
        for (int i = 0; i < 60; i++) begin
            rnd = $random(seed);
            send_pixel(rnd >>> 22, rnd <<< 10 >>> 23);
            gap = $random(seed) & 3;
            idle(gap);
        end
        wait_drain();
        idle(4);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- vlog.f
rtl/lens_pkg.sv
rtl/axis_sq_if.sv
rtl/axis_offset_squarer.sv
rtl/radius_delta_mapper.sv
rtl/delta_generator.sv
tb/delta_generator_assertions.sv
tb/tb_delta_generator.sv
